/* all.f */
hdl/dcache_cfg_pkg.sv
hdl/dcache_types_pkg.sv
hdl/sram_array.sv
hdl/cache_ctrl.sv
hdl/miss_handler.sv
hdl/dcache_top.sv
testbench/tb_clock.sv
testbench/wb_mem_model.sv
testbench/dcache_assertions.sv
testbench/dcache_tb.sv

/* hdl/cache_ctrl.sv */
// --------------------
// Core-side controller of the data cache.
// The core master must hold its request until core_ack_o.
// flush_i is taken only when no core access is pending.
// Hit latency is lookup plus compare, ack one cycle later.
// --------------------
`default_nettype none

module cache_ctrl
  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  output logic                  flush_ack_o,
  output logic                  busy_o,
  // Core Wishbone slave
  input  logic                  core_cyc_i,
  input  logic                  core_stb_i,
  input  logic                  core_we_i,
  input  logic [ADDR_WIDTH-1:0] core_adr_i,
  input  sel_t                  core_sel_i,
  input  word_t                 core_dat_i,
  output word_t                 core_dat_o,
  output logic                  core_ack_o,
  // Tag array
  output logic                  tag_req_o,
  output logic                  tag_we_o,
  output line_idx_t             tag_addr_o,
  output tag_t                  tag_wdata_o,
  input  tag_t                  tag_rdata_i,
  // Data array
  output logic                  data_req_o,
  output logic                  data_we_o,
  output data_idx_t             data_addr_o,
  output word_t                 data_wdata_o,
  input  word_t                 data_rdata_i,
  // Miss handler
  output logic                  miss_start_o,
  output line_idx_t             miss_index_o,
  output tag_t                  victim_tag_o,
  output logic                  do_writeback_o,
  output logic                  do_refill_o,
  output tag_t                  refill_tag_o,
  input  logic                  miss_done_i,
  input  logic                  mh_arr_we_i,
  input  data_idx_t             mh_arr_addr_i,
  input  word_t                 mh_arr_wdata_i,
  output word_t                 mh_arr_rdata_o
);

  typedef enum logic [3:0] {
    S_IDLE, S_LOOKUP, S_COMPARE, S_ACK, S_MISS,
    S_FL_READ, S_FL_CHECK, S_FL_WAIT, S_FL_ACK
  } state_e;

  state_e                    state_q;
  logic [NUM_LINES-1:0]      valid_q;
  logic [NUM_LINES-1:0]      dirty_q;
  line_idx_t                 fl_idx_q;
  tag_t                      req_tag;
  line_idx_t                 req_idx;
  logic [WORD_SEL_WIDTH-1:0] req_word;
  logic                      hit;
  logic                      store_hit;
  logic                      fl_dirty;
  logic                      fl_step;
  logic                      mh_owns;
  word_t                     merged;

  // --------------------
  // Address split and compare
  // --------------------
  assign req_tag   = core_adr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign req_idx   = core_adr_i[OFFSET_WIDTH+WORD_SEL_WIDTH +: INDEX_WIDTH];
  assign req_word  = core_adr_i[OFFSET_WIDTH +: WORD_SEL_WIDTH];
  assign hit       = valid_q[req_idx] && (tag_rdata_i == req_tag);
  assign store_hit = (state_q == S_COMPARE) && hit && core_we_i;

  // Byte merge of a store into the word just read
  always_comb begin
    for (int b = 0; b < WORD_WIDTH / 8; b++) begin
      merged[8*b +: 8] = core_sel_i[b] ? core_dat_i[8*b +: 8] : data_rdata_i[8*b +: 8];
    end
  end

  // Flush walk moves on after a clean line or a finished write-back
  assign fl_dirty = valid_q[fl_idx_q] && dirty_q[fl_idx_q];
  assign fl_step  = ((state_q == S_FL_CHECK) && !fl_dirty) ||
                    ((state_q == S_FL_WAIT) && miss_done_i);

  // --------------------
  // Array access
  // --------------------
  assign tag_we_o    = (state_q == S_MISS) && miss_done_i;
  assign tag_req_o   = (state_q == S_LOOKUP) || (state_q == S_FL_READ) || tag_we_o;
  assign tag_addr_o  = (state_q == S_FL_READ) ? fl_idx_q : req_idx;
  assign tag_wdata_o = req_tag;

  // Miss handler drives the data array while a request is open
  assign mh_owns        = (state_q == S_MISS) || (state_q == S_FL_WAIT);
  assign data_req_o     = mh_owns || (state_q == S_LOOKUP) || store_hit;
  assign data_we_o      = mh_owns ? mh_arr_we_i : store_hit;
  assign data_addr_o    = mh_owns ? mh_arr_addr_i : {req_idx, req_word};
  assign data_wdata_o   = mh_owns ? mh_arr_wdata_i : merged;
  assign mh_arr_rdata_o = data_rdata_i;

  assign core_ack_o  = (state_q == S_ACK);
  assign flush_ack_o = (state_q == S_FL_ACK);
  assign busy_o      = (state_q == S_MISS) || (state_q == S_FL_READ) ||
                       (state_q == S_FL_CHECK) || (state_q == S_FL_WAIT);

  // --------------------
  // Control FSM
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= S_IDLE;
      valid_q      <= '0;
      dirty_q      <= '0;
      fl_idx_q     <= '0;
      miss_start_o <= 1'b0;
    end else begin
      miss_start_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (core_cyc_i && core_stb_i) begin
            state_q <= S_LOOKUP;
          end else if (flush_i) begin
            fl_idx_q <= '0;
            state_q  <= S_FL_READ;
          end
        end
        S_LOOKUP: state_q <= S_COMPARE;
        S_COMPARE: begin
          if (hit) begin
            state_q <= S_ACK;
            if (core_we_i) begin
              dirty_q[req_idx] <= 1'b1;
            end
          end else begin
            miss_start_o <= 1'b1;
            state_q      <= S_MISS;
          end
        end
        S_ACK: state_q <= S_IDLE;
        S_MISS: begin
          // Line now holds the new tag; replay the access as a hit
          if (miss_done_i) begin
            valid_q[req_idx] <= 1'b1;
            dirty_q[req_idx] <= 1'b0;
            state_q          <= S_LOOKUP;
          end
        end
        S_FL_READ: state_q <= S_FL_CHECK;
        S_FL_CHECK: begin
          if (fl_dirty) begin
            miss_start_o <= 1'b1;
            state_q      <= S_FL_WAIT;
          end
        end
        S_FL_WAIT: begin
          if (miss_done_i) begin
            dirty_q[fl_idx_q] <= 1'b0;
          end
        end
        S_FL_ACK: state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase

      if (fl_step) begin
        if (fl_idx_q == line_idx_t'(NUM_LINES - 1)) begin
          valid_q <= '0;
          state_q <= S_FL_ACK;
        end else begin
          fl_idx_q <= fl_idx_q + 1'b1;
          state_q  <= S_FL_READ;
        end
      end
    end
  end

  // Request payload, qualified by miss_start_o and core_ack_o
  always_ff @(posedge clk_i) begin
    if (state_q == S_COMPARE) begin
      core_dat_o     <= data_rdata_i;
      miss_index_o   <= req_idx;
      victim_tag_o   <= tag_rdata_i;
      do_writeback_o <= valid_q[req_idx] && dirty_q[req_idx];
      do_refill_o    <= 1'b1;
      refill_tag_o   <= req_tag;
    end else if (state_q == S_FL_CHECK) begin
      miss_index_o   <= fl_idx_q;
      victim_tag_o   <= tag_rdata_i;
      do_writeback_o <= 1'b1;
      do_refill_o    <= 1'b0;
      refill_tag_o   <= tag_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/dcache_cfg_pkg.sv */
// --------------------
// Geometry of the direct-mapped data cache.
// NUM_LINES and WORDS_PER_LINE must be powers of two.
// Address fields are derived from the sizes below.
// --------------------
`default_nettype none

package dcache_cfg_pkg;

  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned WORD_WIDTH     = 32;
  localparam int unsigned NUM_LINES      = 16;
  localparam int unsigned WORDS_PER_LINE = 4;

  // Address split: tag | index | word in line | byte in word
  localparam int unsigned OFFSET_WIDTH   = $clog2(WORD_WIDTH / 8);
  localparam int unsigned WORD_SEL_WIDTH = $clog2(WORDS_PER_LINE);
  localparam int unsigned INDEX_WIDTH    = $clog2(NUM_LINES);
  localparam int unsigned TAG_WIDTH      =
      ADDR_WIDTH - INDEX_WIDTH - WORD_SEL_WIDTH - OFFSET_WIDTH;

  localparam int unsigned DATA_DEPTH     = NUM_LINES * WORDS_PER_LINE;

endpackage

`default_nettype wire

/* hdl/dcache_top.sv */
// --------------------
// Write-back direct-mapped data cache.
// Core side is a Wishbone classic slave, memory side a master.
// One access in flight at a time.
// --------------------
`default_nettype none

module dcache_top (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 flush_i,
  output logic                                 flush_ack_o,
  output logic                                 busy_o,
  // Core port
  input  logic                                 core_cyc_i,
  input  logic                                 core_stb_i,
  input  logic                                 core_we_i,
  input  logic [dcache_cfg_pkg::ADDR_WIDTH-1:0] core_adr_i,
  input  dcache_types_pkg::sel_t               core_sel_i,
  input  dcache_types_pkg::word_t              core_dat_i,
  output dcache_types_pkg::word_t              core_dat_o,
  output logic                                 core_ack_o,
  // Memory port
  output logic                                 mem_cyc_o,
  output logic                                 mem_stb_o,
  output logic                                 mem_we_o,
  output logic [dcache_cfg_pkg::ADDR_WIDTH-1:0] mem_adr_o,
  output dcache_types_pkg::word_t              mem_dat_o,
  input  dcache_types_pkg::word_t              mem_dat_i,
  input  logic                                 mem_ack_i
);

  // Tag array
  logic                        tag_req;
  logic                        tag_we;
  dcache_types_pkg::line_idx_t tag_addr;
  dcache_types_pkg::tag_t      tag_wdata;
  dcache_types_pkg::tag_t      tag_rdata;
  // Data array
  logic                        data_req;
  logic                        data_we;
  dcache_types_pkg::data_idx_t data_addr;
  dcache_types_pkg::word_t     data_wdata;
  dcache_types_pkg::word_t     data_rdata;
  // Miss request
  logic                        miss_start;
  dcache_types_pkg::line_idx_t miss_index;
  dcache_types_pkg::tag_t      victim_tag;
  logic                        do_writeback;
  logic                        do_refill;
  dcache_types_pkg::tag_t      refill_tag;
  logic                        miss_done;
  logic                        mh_arr_we;
  dcache_types_pkg::data_idx_t mh_arr_addr;
  dcache_types_pkg::word_t     mh_arr_wdata;
  dcache_types_pkg::word_t     mh_arr_rdata;

  cache_ctrl u_cache_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .flush_ack_o    (flush_ack_o),
    .busy_o         (busy_o),
    .core_cyc_i     (core_cyc_i),
    .core_stb_i     (core_stb_i),
    .core_we_i      (core_we_i),
    .core_adr_i     (core_adr_i),
    .core_sel_i     (core_sel_i),
    .core_dat_i     (core_dat_i),
    .core_dat_o     (core_dat_o),
    .core_ack_o     (core_ack_o),
    .tag_req_o      (tag_req),
    .tag_we_o       (tag_we),
    .tag_addr_o     (tag_addr),
    .tag_wdata_o    (tag_wdata),
    .tag_rdata_i    (tag_rdata),
    .data_req_o     (data_req),
    .data_we_o      (data_we),
    .data_addr_o    (data_addr),
    .data_wdata_o   (data_wdata),
    .data_rdata_i   (data_rdata),
    .miss_start_o   (miss_start),
    .miss_index_o   (miss_index),
    .victim_tag_o   (victim_tag),
    .do_writeback_o (do_writeback),
    .do_refill_o    (do_refill),
    .refill_tag_o   (refill_tag),
    .miss_done_i    (miss_done),
    .mh_arr_we_i    (mh_arr_we),
    .mh_arr_addr_i  (mh_arr_addr),
    .mh_arr_wdata_i (mh_arr_wdata),
    .mh_arr_rdata_o (mh_arr_rdata)
  );

  sram_array #(
    .entry_t (dcache_types_pkg::tag_t),
    .DEPTH   (dcache_cfg_pkg::NUM_LINES)
  ) u_tag_array (
    .clk_i   (clk_i),
    .req_i   (tag_req),
    .we_i    (tag_we),
    .addr_i  (tag_addr),
    .wdata_i (tag_wdata),
    .rdata_o (tag_rdata)
  );

  sram_array #(
    .entry_t (dcache_types_pkg::word_t),
    .DEPTH   (dcache_cfg_pkg::DATA_DEPTH)
  ) u_data_array (
    .clk_i   (clk_i),
    .req_i   (data_req),
    .we_i    (data_we),
    .addr_i  (data_addr),
    .wdata_i (data_wdata),
    .rdata_o (data_rdata)
  );

  miss_handler u_miss_handler (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .miss_start_i   (miss_start),
    .miss_index_i   (miss_index),
    .victim_tag_i   (victim_tag),
    .do_writeback_i (do_writeback),
    .do_refill_i    (do_refill),
    .refill_tag_i   (refill_tag),
    .miss_done_o    (miss_done),
    .arr_we_o       (mh_arr_we),
    .arr_addr_o     (mh_arr_addr),
    .arr_wdata_o    (mh_arr_wdata),
    .arr_rdata_i    (mh_arr_rdata),
    .mem_cyc_o      (mem_cyc_o),
    .mem_stb_o      (mem_stb_o),
    .mem_we_o       (mem_we_o),
    .mem_adr_o      (mem_adr_o),
    .mem_dat_o      (mem_dat_o),
    .mem_dat_i      (mem_dat_i),
    .mem_ack_i      (mem_ack_i)
  );

endmodule

`default_nettype wire

/* hdl/dcache_types_pkg.sv */
// --------------------
// Payload types of the cache, sized from the geometry.
// --------------------
`default_nettype none

package dcache_types_pkg;

  import dcache_cfg_pkg::*;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [TAG_WIDTH-1:0]  tag_t;
  typedef logic [INDEX_WIDTH-1:0] line_idx_t;

  // Data array address is {line index, word in line}
  typedef logic [INDEX_WIDTH+WORD_SEL_WIDTH-1:0] data_idx_t;

  typedef logic [WORD_WIDTH/8-1:0] sel_t;

endpackage

`default_nettype wire

/* hdl/miss_handler.sv */
// --------------------
// Memory-side Wishbone classic master.
// Moves whole words only, no select lines.
// Refill beats may follow each other back to back.
// The word counter wraps, so WORDS_PER_LINE is a power of two.
// --------------------
`default_nettype none

module miss_handler
  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Request from the controller
  input  logic                  miss_start_i,
  input  line_idx_t             miss_index_i,
  input  tag_t                  victim_tag_i,
  input  logic                  do_writeback_i,
  input  logic                  do_refill_i,
  input  tag_t                  refill_tag_i,
  output logic                  miss_done_o,
  // Data array, routed through the controller
  output logic                  arr_we_o,
  output data_idx_t             arr_addr_o,
  output word_t                 arr_wdata_o,
  input  word_t                 arr_rdata_i,
  // Memory Wishbone master
  output logic                  mem_cyc_o,
  output logic                  mem_stb_o,
  output logic                  mem_we_o,
  output logic [ADDR_WIDTH-1:0] mem_adr_o,
  output word_t                 mem_dat_o,
  input  word_t                 mem_dat_i,
  input  logic                  mem_ack_i
);

  typedef enum logic [2:0] {
    M_IDLE, M_WB_READ, M_WB_SEND, M_RF_REQ, M_DONE
  } mstate_e;

  mstate_e                   state_q;
  logic [WORD_SEL_WIDTH-1:0] cnt_q;
  line_idx_t                 idx_q;
  tag_t                      vtag_q;
  tag_t                      rtag_q;
  logic                      refill_q;
  logic                      last_word;

  assign last_word = (cnt_q == WORD_SEL_WIDTH'(WORDS_PER_LINE - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= M_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        M_IDLE: begin
          if (miss_start_i) begin
            cnt_q <= '0;
            if (do_writeback_i) begin
              state_q <= M_WB_READ;
            end else if (do_refill_i) begin
              state_q <= M_RF_REQ;
            end else begin
              state_q <= M_DONE;
            end
          end
        end
        // Array read one cycle ahead of each write beat
        M_WB_READ: state_q <= M_WB_SEND;
        M_WB_SEND: begin
          if (mem_ack_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (!last_word) begin
              state_q <= M_WB_READ;
            end else if (refill_q) begin
              state_q <= M_RF_REQ;
            end else begin
              state_q <= M_DONE;
            end
          end
        end
        M_RF_REQ: begin
          if (mem_ack_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_word) begin
              state_q <= M_DONE;
            end
          end
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if ((state_q == M_IDLE) && miss_start_i) begin
      idx_q    <= miss_index_i;
      vtag_q   <= victim_tag_i;
      rtag_q   <= refill_tag_i;
      refill_q <= do_refill_i;
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign miss_done_o = (state_q == M_DONE);

  assign arr_addr_o  = {idx_q, cnt_q};
  assign arr_we_o    = (state_q == M_RF_REQ) && mem_ack_i;
  assign arr_wdata_o = mem_dat_i;

  // cyc stays up between beats and from write-back into refill
  assign mem_cyc_o = (state_q == M_WB_READ) || (state_q == M_WB_SEND) ||
                     (state_q == M_RF_REQ);
  assign mem_stb_o = (state_q == M_WB_SEND) || (state_q == M_RF_REQ);
  assign mem_we_o  = (state_q == M_WB_SEND);
  assign mem_adr_o = {(state_q == M_RF_REQ) ? rtag_q : vtag_q, idx_q, cnt_q,
                      {OFFSET_WIDTH{1'b0}}};
  assign mem_dat_o = arr_rdata_i;

endmodule

`default_nettype wire

/* hdl/sram_array.sv */
// --------------------
// Single-port synchronous RAM, one cycle read latency.
// A write leaves rdata_o unchanged.
// No reset on contents.
// --------------------
`default_nettype none

module sram_array #(
  parameter type         entry_t = logic,
  parameter int unsigned DEPTH   = 16
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  entry_t                   wdata_i,
  output entry_t                   rdata_o
);

  entry_t mem [DEPTH];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/dcache_assertions.sv */
// --------------------
// Protocol checks bound into dcache_top.
// Inactive while rst_n_i is low.
// --------------------
`default_nettype none

module dcache_assertions (
  input logic clk_i,
  input logic rst_n_i,
  input logic core_cyc_i,
  input logic core_stb_i,
  input logic core_ack_i,
  input logic mem_cyc_i,
  input logic mem_stb_i,
  input logic mem_ack_i,
  input logic flush_ack_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  ack_needs_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      core_ack_i |-> (core_cyc_i && core_stb_i))
    else begin
      fail_count++;
      $error("core_ack_o high without an active core request");
    end

  // A memory beat stays requested inside the cycle until it is acked
  stb_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (mem_stb_i && !mem_ack_i) |=> (mem_cyc_i && mem_stb_i))
    else begin
      fail_count++;
      $error("mem_stb_o or mem_cyc_o dropped before mem_ack_i");
    end

  // Flush acknowledge is a single-cycle pulse
  flush_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flush_ack_i |=> !flush_ack_i)
    else begin
      fail_count++;
      $error("flush_ack_o high for two cycles");
    end

endmodule

bind dcache_top dcache_assertions u_assertions (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .core_cyc_i  (core_cyc_i),
  .core_stb_i  (core_stb_i),
  .core_ack_i  (core_ack_o),
  .mem_cyc_i   (mem_cyc_o),
  .mem_stb_i   (mem_stb_o),
  .mem_ack_i   (mem_ack_i),
  .flush_ack_i (flush_ack_o)
);

`default_nettype wire

/* testbench/dcache_tb.sv */
// --------------------
// Directed tests for the write-back data cache.
// Inputs change on the falling clock edge.
// A core request stays up one cycle past core_ack_o.
// A reference memory and a tag model predict data and memory traffic.
// All addresses stay inside the 4 KB memory model.
// --------------------
`default_nettype none

module dcache_tb
  import dcache_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned MEM_WORDS      = 1024;
  localparam int unsigned MEM_AW         = $clog2(MEM_WORDS);
  localparam int unsigned TIMEOUT_CYCLES = 500;
  localparam int unsigned LINE_LSB       = OFFSET_WIDTH + WORD_SEL_WIDTH;
  localparam int unsigned TAG_LSB        = LINE_LSB + INDEX_WIDTH;

  logic                    clk;
  logic                    rst_n;
  logic                    flush;
  logic                    flush_ack;
  logic                    busy;
  logic                    core_cyc;
  logic                    core_stb;
  logic                    core_we;
  logic                    core_ack;
  logic [ADDR_WIDTH-1:0]   core_adr;
  logic [WORD_WIDTH/8-1:0] core_sel;
  logic [WORD_WIDTH-1:0]   core_wdata;
  logic [WORD_WIDTH-1:0]   core_rdata;
  logic                    mem_cyc;
  logic                    mem_stb;
  logic                    mem_we;
  logic                    mem_ack;
  logic [ADDR_WIDTH-1:0]   mem_adr;
  logic [WORD_WIDTH-1:0]   mem_wdata;
  logic [WORD_WIDTH-1:0]   mem_rdata;
  int unsigned             mem_reads;
  int unsigned             mem_writes;

  // Reference state
  logic [WORD_WIDTH-1:0]   ref_mem [MEM_WORDS];
  logic [TAG_WIDTH-1:0]    model_tag [NUM_LINES];
  logic [NUM_LINES-1:0]    model_valid;
  logic [NUM_LINES-1:0]    model_dirty;
  int unsigned             errors;
  logic [31:0]             rng;

  tb_clock u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dcache_top dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .flush_ack_o (flush_ack),
    .busy_o      (busy),
    .core_cyc_i  (core_cyc),
    .core_stb_i  (core_stb),
    .core_we_i   (core_we),
    .core_adr_i  (core_adr),
    .core_sel_i  (core_sel),
    .core_dat_i  (core_wdata),
    .core_dat_o  (core_rdata),
    .core_ack_o  (core_ack),
    .mem_cyc_o   (mem_cyc),
    .mem_stb_o   (mem_stb),
    .mem_we_o    (mem_we),
    .mem_adr_o   (mem_adr),
    .mem_dat_o   (mem_wdata),
    .mem_dat_i   (mem_rdata),
    .mem_ack_i   (mem_ack)
  );

  wb_mem_model #(
    .WORDS (MEM_WORDS)
  ) u_mem (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .mem_cyc_i     (mem_cyc),
    .mem_stb_i     (mem_stb),
    .mem_we_i      (mem_we),
    .mem_adr_i     (mem_adr),
    .mem_dat_i     (mem_wdata),
    .mem_dat_o     (mem_rdata),
    .mem_ack_o     (mem_ack),
    .read_count_o  (mem_reads),
    .write_count_o (mem_writes)
  );

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0d ns: %s", $time, what);
    $display("Errors: %0d", errors + 1);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic wait_reset_release();
    int unsigned cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      stop_on_timeout("reset was never released");
    end
  endtask

  // Latency counts cycles from the edge that samples the request
  task automatic wait_core_ack(output int unsigned latency, output logic busy_seen);
    int unsigned cycles;
    cycles    = 0;
    busy_seen = 1'b0;
    do begin
      @(negedge clk);
      cycles++;
      busy_seen = busy_seen | busy;
    end while (!core_ack && cycles < TIMEOUT_CYCLES);
    if (!core_ack) begin
      stop_on_timeout("core_ack_o did not rise");
    end else begin
      latency = cycles - 1;
    end
  endtask

  // One core access, checked against the reference memory and tag model
  task automatic core_access(input logic we, input logic [ADDR_WIDTH-1:0] adr,
                             input logic [3:0] sel, input logic [31:0] wdata,
                             output int unsigned latency);
    int unsigned            reads0;
    int unsigned            writes0;
    int unsigned            widx;
    int unsigned            vbase;
    logic [INDEX_WIDTH-1:0] idx;
    logic [TAG_WIDTH-1:0]   tag;
    logic                   hit;
    logic                   writeback;
    logic                   busy_seen;
    widx      = adr[OFFSET_WIDTH +: MEM_AW];
    idx       = adr[LINE_LSB +: INDEX_WIDTH];
    tag       = adr[TAG_LSB +: TAG_WIDTH];
    hit       = model_valid[idx] && (model_tag[idx] == tag);
    writeback = !hit && model_valid[idx] && model_dirty[idx];
    vbase     = {model_tag[idx], idx} * WORDS_PER_LINE;
    reads0    = mem_reads;
    writes0   = mem_writes;
    @(negedge clk);
    core_cyc   = 1'b1;
    core_stb   = 1'b1;
    core_we    = we;
    core_adr   = adr;
    core_sel   = sel;
    core_wdata = wdata;
    wait_core_ack(latency, busy_seen);
    if (!we) begin
      check_equal("core_dat_o", core_rdata, ref_mem[widx]);
    end
    // A miss keeps the cache busy, a hit never does
    check_equal("busy_o", busy_seen, !hit);
    check_equal("memory reads", mem_reads - reads0, hit ? 0 : WORDS_PER_LINE);
    check_equal("memory writes", mem_writes - writes0, writeback ? WORDS_PER_LINE : 0);
    if (writeback) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        check_equal($sformatf("mem word %0d", vbase + w), u_mem.words[vbase + w],
                    ref_mem[vbase + w]);
      end
    end
    @(negedge clk);
    core_cyc = 1'b0;
    core_stb = 1'b0;
    core_we  = 1'b0;
    if (!hit) begin
      model_valid[idx] = 1'b1;
      model_tag[idx]   = tag;
      model_dirty[idx] = 1'b0;
    end
    if (we) begin
      for (int b = 0; b < WORD_WIDTH / 8; b++) begin
        if (sel[b]) begin
          ref_mem[widx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      model_dirty[idx] = 1'b1;
    end
  endtask

  task automatic flush_cache(output int unsigned writes);
    int unsigned writes0;
    int unsigned reads0;
    int unsigned expected;
    int unsigned cycles;
    logic        busy_seen;
    expected = 0;
    for (int i = 0; i < NUM_LINES; i++) begin
      if (model_valid[i] && model_dirty[i]) begin
        expected += WORDS_PER_LINE;
      end
    end
    writes0 = mem_writes;
    reads0  = mem_reads;
    @(negedge clk);
    flush     = 1'b1;
    cycles    = 0;
    busy_seen = 1'b0;
    do begin
      @(negedge clk);
      cycles++;
      busy_seen = busy_seen | busy;
    end while (!flush_ack && cycles < TIMEOUT_CYCLES);
    if (!flush_ack) begin
      stop_on_timeout("flush_ack_o did not rise");
    end else begin
      flush  = 1'b0;
      writes = mem_writes - writes0;
      check_equal("busy_o", busy_seen, 1'b1);
      check_equal("memory writes", writes, expected);
      check_equal("memory reads", mem_reads - reads0, 0);
      model_valid = '0;
      model_dirty = '0;
      // Single pulse, then idle
      repeat (3) begin
        @(negedge clk);
        check_equal("flush_ack_o", flush_ack, 1'b0);
      end
      check_equal("busy_o", busy, 1'b0);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_load_miss();
    int unsigned latency;
    core_access(1'b0, 32'h0000_0104, 4'hf, '0, latency);
    check_equal("core_dat_o", core_rdata, 32'h5a5a_0041);
  endtask

  task automatic test_load_hit();
    int unsigned latency;
    core_access(1'b0, 32'h0000_010c, 4'hf, '0, latency);
    check_equal("load hit latency", latency, 2);
  endtask

  task automatic test_byte_store_hit();
    int unsigned latency;
    core_access(1'b1, 32'h0000_0108, 4'b0101, 32'hdead_beef, latency);
    check_equal("store hit latency", latency, 2);
    core_access(1'b0, 32'h0000_0108, 4'hf, '0, latency);
    check_equal("core_dat_o", core_rdata, 32'h5aad_00ef);
  endtask

  // Same index 0, tag 2 evicts the dirty tag 1 line
  task automatic test_dirty_conflict();
    int unsigned latency;
    core_access(1'b0, 32'h0000_0208, 4'hf, '0, latency);
    check_equal("mem word 66", u_mem.words[66], 32'h5aad_00ef);
  endtask

  task automatic test_flush();
    int unsigned latency;
    int unsigned writes;
    core_access(1'b1, 32'h0000_0310, 4'hf, 32'h1111_2222, latency);
    core_access(1'b1, 32'h0000_0424, 4'b1100, 32'h3333_4444, latency);
    flush_cache(writes);
    check_equal("flush write count", writes, 8);
    check_equal("mem word 196", u_mem.words[196], 32'h1111_2222);
    check_equal("mem word 265", u_mem.words[265], 32'h3333_0109);
    core_access(1'b0, 32'h0000_0310, 4'hf, '0, latency);
    core_access(1'b0, 32'h0000_0424, 4'hf, '0, latency);
  endtask

  // 64 words: tags 0..3, lines 0..3, all words of a line
  task automatic test_random_mix();
    logic [31:0]           r;
    logic [31:0]           wdata;
    logic [ADDR_WIDTH-1:0] adr;
    logic [3:0]            sel;
    int unsigned           latency;
    int unsigned           writes;
    for (int n = 0; n < 200; n++) begin
      rng   = xorshift32(rng);
      r     = rng;
      rng   = xorshift32(rng);
      wdata = rng;
      adr   = {22'b0, r[1:0], 2'b00, r[3:2], r[5:4], 2'b00};
      sel   = (r[11:8] == 4'h0) ? 4'hf : r[11:8];
      core_access(r[16], adr, sel, wdata, latency);
    end
    flush_cache(writes);
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_equal($sformatf("mem word %0d", i), u_mem.words[i], ref_mem[i]);
    end
  endtask

  initial begin
    errors      = 0;
    rng         = 32'hd2ca;
    flush       = 1'b0;
    core_cyc    = 1'b0;
    core_stb    = 1'b0;
    core_we     = 1'b0;
    core_adr    = '0;
    core_sel    = '0;
    core_wdata  = '0;
    model_valid = '0;
    model_dirty = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = i ^ 32'h5a5a0000;
    end
    for (int i = 0; i < NUM_LINES; i++) begin
      model_tag[i] = '0;
    end

    wait_reset_release();
    check_equal("core_ack_o", core_ack, 1'b0);
    check_equal("flush_ack_o", flush_ack, 1'b0);
    check_equal("busy_o", busy, 1'b0);
    check_equal("mem_cyc_o", mem_cyc, 1'b0);
    check_equal("mem_stb_o", mem_stb, 1'b0);

    test_load_miss();
    test_load_hit();
    test_byte_store_hit();
    test_dirty_conflict();
    test_flush();
    test_random_mix();

    errors += dut.u_assertions.fail_count;
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// --------------------
// Free-running 10 ns clock.
// Reset low for the first 2 rising edges, released on a falling edge.
// --------------------
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/wb_mem_model.sv */
// --------------------
// Wishbone classic memory slave, whole words only.
// Acks one cycle after it sees a strobe, then drops ack for a cycle.
// Addresses wrap at WORDS words, upper bits are ignored.
// Word i starts as i XOR 32'h5a5a0000.
// --------------------
`default_nettype none

module wb_mem_model #(
  parameter int unsigned WORDS = 1024
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        mem_cyc_i,
  input  logic        mem_stb_i,
  input  logic        mem_we_i,
  input  logic [31:0] mem_adr_i,
  input  logic [31:0] mem_dat_i,
  output logic [31:0] mem_dat_o,
  output logic        mem_ack_o,
  output int unsigned read_count_o,
  output int unsigned write_count_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0]              words [WORDS];
  logic [$clog2(WORDS)-1:0] word_addr;

  assign word_addr = mem_adr_i[2 +: $clog2(WORDS)];

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      words[i] = i ^ 32'h5a5a0000;
    end
    mem_dat_o     = '0;
    mem_ack_o     = 1'b0;
    read_count_o  = 0;
    write_count_o = 0;
  end

  // One transfer per strobe, counted when it is acked
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_ack_o     <= 1'b0;
      read_count_o  <= 0;
      write_count_o <= 0;
    end else if (mem_cyc_i && mem_stb_i && !mem_ack_o) begin
      mem_ack_o <= 1'b1;
      if (mem_we_i) begin
        words[word_addr] <= mem_dat_i;
        write_count_o    <= write_count_o + 1;
      end else begin
        mem_dat_o    <= words[word_addr];
        read_count_o <= read_count_o + 1;
      end
    end else begin
      mem_ack_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire
